/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := core_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* source/alu4.sv */
`default_nettype none

module alu4 import core_pkg::*; (
  input  alu_op      op,
  input  logic [3:0] a,
  input  logic [3:0] b,
  input  logic       carry_in,
  output logic [3:0] result,
  output logic       zero,
  output logic       carry
);

  // One extra bit holds carry out or borrow
  logic [4:0] sum;

  always_comb begin
    sum = 5'h00;
    case (op)
      ALU_ADD: begin
        sum = {1'b0, a} + {1'b0, b};
      end
      ALU_ADC: begin
        sum = {1'b0, a} + {1'b0, b} + {4'h0, carry_in};
      end
      ALU_SUB: begin
        // Bit 4 set means borrow
        sum = {1'b0, a} - {1'b0, b};
      end
      ALU_AND: begin
        sum = {1'b0, a & b};
      end
      ALU_OR: begin
        sum = {1'b0, a | b};
      end
      ALU_XOR: begin
        sum = {1'b0, a ^ b};
      end
      ALU_PASS_B: begin
        sum = {1'b0, b};
      end
      default: begin
        sum = 5'h00;
      end
    endcase
  end

  assign result = sum[3:0];
  // Logic ops leave bit 4 clear, so carry drops
  assign carry  = sum[4];
  assign zero   = (sum[3:0] == 4'h0);

endmodule

`default_nettype wire

/* source/core_pkg.sv */
`default_nettype none

package core_pkg;

  localparam int OPCODE_W   = 12;
  localparam int MEM_ADDR_W = 12;
  // 1 bank bit, 4 page bits, 8 step bits
  localparam int PC_W       = 13;
  // Bank 0, page 1, step 0
  localparam logic [PC_W-1:0] PC_RESET = 13'h0_1_00;

  // Phase of the instruction in flight
  typedef enum logic [1:0] {
    CYCLE_IDLE,
    CYCLE_REG_FETCH,
    CYCLE_REG_WRITE
  } micro_cycle;

  // Bus endpoints, used as source and destination selectors
  typedef enum logic [3:0] {
    REG_NONE,
    REG_A,
    REG_B,
    REG_XL,
    REG_XH,
    REG_XP,
    REG_MX,
    REG_IMM,
    REG_ALU,
    REG_ALU_WITH_FLAGS,
    REG_NPP,
    REG_SETPC
  } reg_sel;

  typedef enum logic {
    REG_INC_NONE,
    REG_XHL
  } reg_inc_sel;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_ADC,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op;

  // Major opcode, instr[11:8]
  localparam logic [3:0] OPC_JP  = 4'h0;
  localparam logic [3:0] OPC_ALU = 4'hA;
  localparam logic [3:0] OPC_LDI = 4'hE;
  localparam logic [3:0] OPC_MEM = 4'hF;

  // Immediate load target in instr[7:4], nibble in instr[3:0]
  localparam logic [3:0] LDI_A  = 4'h0;
  localparam logic [3:0] LDI_B  = 4'h1;
  localparam logic [3:0] LDI_XL = 4'h2;
  localparam logic [3:0] LDI_XH = 4'h3;
  localparam logic [3:0] LDI_XP = 4'h4;
  localparam logic [3:0] LDI_NP = 4'h5;

  // ALU function in instr[7:4], destination in instr[3:2], source in instr[1:0]
  localparam logic [3:0] ALU_FN_ADD = 4'h8;
  localparam logic [3:0] ALU_FN_ADC = 4'h9;
  localparam logic [3:0] ALU_FN_SUB = 4'hA;
  localparam logic [3:0] ALU_FN_AND = 4'hC;
  localparam logic [3:0] ALU_FN_OR  = 4'hD;
  localparam logic [3:0] ALU_FN_XOR = 4'hE;

  // Register codes for ALU and memory operands
  localparam logic [1:0] RC_A = 2'b00;
  localparam logic [1:0] RC_B = 2'b01;

  // Memory op control bits, register code in instr[1:0]
  localparam int MEM_LOAD_BIT = 7;
  localparam int MEM_INC_BIT  = 6;

endpackage

`default_nettype wire

/* source/core_top.sv */
`default_nettype none

module core_top import core_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [OPCODE_W-1:0]   instr,
  input  logic                  instr_valid,
  output logic                  ready,
  output logic [3:0]            a,
  output logic [3:0]            b,
  output logic [MEM_ADDR_W-1:0] x,
  output logic [PC_W-1:0]       pc,
  output logic                  zero,
  output logic                  carry
);

  micro_op_if uop ();

  logic [3:0]            alu_a;
  logic [3:0]            alu_b;
  logic                  alu_carry_in;
  logic [3:0]            alu_result;
  logic                  alu_zero;
  logic                  alu_carry;

  logic [MEM_ADDR_W-1:0] memory_addr;
  logic [3:0]            memory_write_data;
  logic                  memory_write_en;
  logic [3:0]            memory_read_data;

  instr_decode u_decode (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .ready       (ready),
    .uop         (uop.decode)
  );

  reg_file u_regs (
    .clk               (clk),
    .reset             (reset),
    .uop               (uop.exec),
    .alu_result        (alu_result),
    .alu_zero          (alu_zero),
    .alu_carry         (alu_carry),
    .alu_a             (alu_a),
    .alu_b             (alu_b),
    .carry_in          (alu_carry_in),
    .memory_addr       (memory_addr),
    .memory_write_data (memory_write_data),
    .memory_write_en   (memory_write_en),
    .memory_read_data  (memory_read_data),
    .a                 (a),
    .b                 (b),
    .x                 (x),
    .pc                (pc),
    .zero              (zero),
    .carry             (carry)
  );

  alu4 u_alu (
    .op       (uop.alu_sel),
    .a        (alu_a),
    .b        (alu_b),
    .carry_in (alu_carry_in),
    .result   (alu_result),
    .zero     (alu_zero),
    .carry    (alu_carry)
  );

  // Full data space behind X
  data_ram #(
    .DEPTH (2 ** MEM_ADDR_W)
  ) u_ram (
    .clk        (clk),
    .addr       (memory_addr),
    .write_data (memory_write_data),
    .write_en   (memory_write_en),
    .read_data  (memory_read_data)
  );

endmodule

`default_nettype wire

/* source/data_ram.sv */
`default_nettype none

module data_ram import core_pkg::*; #(
  parameter int DEPTH = 4096
) (
  input  logic                  clk,
  input  logic [MEM_ADDR_W-1:0] addr,
  input  logic [3:0]            write_data,
  input  logic                  write_en,
  output logic [3:0]            read_data
);

  localparam int AW = $clog2(DEPTH);

  // One nibble per address
  logic [3:0] mem [DEPTH];

  // Upper address bits fold onto the smaller array
  logic [AW-1:0] index;

  assign index = addr[AW-1:0];

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[index] <= write_data;
    end
    read_data <= mem[index];
  end

endmodule

`default_nettype wire

/* source/instr_decode.sv */
`default_nettype none

module instr_decode import core_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic [OPCODE_W-1:0] instr,
  input  logic                instr_valid,
  output logic                ready,
  micro_op_if.decode          uop
);

  logic [OPCODE_W-1:0] instr_q;
  // Instruction latched, FETCH starts next edge
  logic                pending;

  reg_sel     src_d;
  reg_sel     dst_d;
  reg_inc_sel inc_d;
  logic       inc_pc_d;
  alu_op      alu_d;
  logic [7:0] imm_d;

  function automatic reg_sel ab_sel(input logic [1:0] code);
    return (code == RC_B) ? REG_B : REG_A;
  endfunction

  assign ready = (uop.current_cycle == CYCLE_IDLE) && !pending;

  always_ff @(posedge clk) begin
    if (ready && instr_valid) begin
      instr_q <= instr;
    end
  end

  // Field decode of the latched instruction
  always_comb begin
    src_d    = REG_NONE;
    dst_d    = REG_NONE;
    inc_d    = REG_INC_NONE;
    inc_pc_d = 1'b1;
    alu_d    = ALU_PASS_B;
    imm_d    = 8'h00;
    case (instr_q[11:8])
      OPC_LDI: begin
        src_d = REG_IMM;
        imm_d = {4'h0, instr_q[3:0]};
        case (instr_q[7:4])
          LDI_A:   dst_d = REG_A;
          LDI_B:   dst_d = REG_B;
          LDI_XL:  dst_d = REG_XL;
          LDI_XH:  dst_d = REG_XH;
          LDI_XP:  dst_d = REG_XP;
          LDI_NP:  dst_d = REG_NPP;
          default: src_d = REG_NONE;
        endcase
      end
      OPC_ALU: begin
        src_d = REG_ALU_WITH_FLAGS;
        dst_d = ab_sel(instr_q[3:2]);
        // immed[0] names the B-side operand register
        imm_d = {7'h00, instr_q[1:0] == RC_B};
        case (instr_q[7:4])
          ALU_FN_ADD: alu_d = ALU_ADD;
          ALU_FN_ADC: alu_d = ALU_ADC;
          ALU_FN_SUB: alu_d = ALU_SUB;
          ALU_FN_AND: alu_d = ALU_AND;
          ALU_FN_OR:  alu_d = ALU_OR;
          ALU_FN_XOR: alu_d = ALU_XOR;
          default: begin
            src_d = REG_NONE;
            dst_d = REG_NONE;
          end
        endcase
      end
      OPC_MEM: begin
        inc_d = instr_q[MEM_INC_BIT] ? REG_XHL : REG_INC_NONE;
        if (instr_q[MEM_LOAD_BIT]) begin
          src_d = REG_MX;
          dst_d = ab_sel(instr_q[1:0]);
        end else begin
          src_d = ab_sel(instr_q[1:0]);
          dst_d = REG_MX;
        end
      end
      OPC_JP: begin
        dst_d    = REG_SETPC;
        imm_d    = instr_q[7:0];
        inc_pc_d = 1'b0;
      end
      // Anything else runs as a NOP and only advances pc
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pending                 <= 1'b0;
      uop.current_cycle       <= CYCLE_IDLE;
      uop.bus_input_selector  <= REG_NONE;
      uop.bus_output_selector <= REG_NONE;
      uop.increment_selector  <= REG_INC_NONE;
      uop.increment_pc        <= 1'b0;
      uop.alu_sel             <= ALU_PASS_B;
      uop.immed               <= 8'h00;
    end else begin
      case (uop.current_cycle)
        CYCLE_IDLE: begin
          if (pending) begin
            pending                 <= 1'b0;
            uop.current_cycle       <= CYCLE_REG_FETCH;
            uop.bus_input_selector  <= src_d;
            uop.bus_output_selector <= dst_d;
            uop.increment_selector  <= inc_d;
            uop.increment_pc        <= inc_pc_d;
            uop.alu_sel             <= alu_d;
            uop.immed               <= imm_d;
          end else if (instr_valid) begin
            pending <= 1'b1;
          end
        end
        CYCLE_REG_FETCH: uop.current_cycle <= CYCLE_REG_WRITE;
        default:         uop.current_cycle <= CYCLE_IDLE;
      endcase
    end
  end

  // Every instruction passes through FETCH before WRITE
  assert property (@(posedge clk) disable iff (reset)
    uop.current_cycle == CYCLE_IDLE |=> uop.current_cycle != CYCLE_REG_WRITE);

endmodule

`default_nettype wire

/* source/micro_op_if.sv */
`default_nettype none

// One micro-operation, decoder to register file
interface micro_op_if import core_pkg::*; ();

  micro_cycle current_cycle;
  reg_sel     bus_input_selector;
  reg_sel     bus_output_selector;
  reg_inc_sel increment_selector;
  logic       increment_pc;
  alu_op      alu_sel;
  logic [7:0] immed;

  modport decode (
    output current_cycle,
    output bus_input_selector,
    output bus_output_selector,
    output increment_selector,
    output increment_pc,
    output alu_sel,
    output immed
  );

  modport exec (
    input current_cycle,
    input bus_input_selector,
    input bus_output_selector,
    input increment_selector,
    input increment_pc,
    input alu_sel,
    input immed
  );

endinterface

`default_nettype wire

/* source/reg_file.sv */
`default_nettype none

module reg_file import core_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  micro_op_if.exec              uop,

  input  logic [3:0]            alu_result,
  input  logic                  alu_zero,
  input  logic                  alu_carry,
  output logic [3:0]            alu_a,
  output logic [3:0]            alu_b,
  output logic                  carry_in,

  output logic [MEM_ADDR_W-1:0] memory_addr,
  output logic [3:0]            memory_write_data,
  output logic                  memory_write_en,
  input  logic [3:0]            memory_read_data,

  output logic [3:0]            a,
  output logic [3:0]            b,
  output logic [MEM_ADDR_W-1:0] x,
  output logic [PC_W-1:0]       pc,
  output logic                  zero,
  output logic                  carry
);

  // New page, copied into the page bits on a jump
  logic [3:0] np;

  logic [3:0]            bus;
  logic [MEM_ADDR_W-1:0] store_addr;
  logic                  is_fetch;
  logic                  is_write;

  assign is_fetch = (uop.current_cycle == CYCLE_REG_FETCH);
  assign is_write = (uop.current_cycle == CYCLE_REG_WRITE);

  // Loads drive X straight to the RAM so data is back in WRITE
  assign memory_addr = (uop.bus_input_selector == REG_MX) ? x : store_addr;

  always_comb begin
    case (uop.bus_input_selector)
      REG_A:              bus = a;
      REG_B:              bus = b;
      REG_XL:             bus = x[3:0];
      REG_XH:             bus = x[7:4];
      REG_XP:             bus = x[11:8];
      REG_MX:             bus = memory_read_data;
      REG_IMM:            bus = uop.immed[3:0];
      REG_ALU:            bus = alu_result;
      REG_ALU_WITH_FLAGS: bus = alu_result;
      REG_NPP:            bus = np;
      default:            bus = 4'h0;
    endcase
  end

  // A-side is the destination, B-side named by immed[0]
  assign alu_a    = (uop.bus_output_selector == REG_B) ? b : a;
  assign alu_b    = uop.immed[0] ? b : a;
  assign carry_in = carry;

  // Store address and data are taken in FETCH
  always_ff @(posedge clk) begin
    if (is_fetch && uop.bus_output_selector == REG_MX) begin
      store_addr        <= x;
      memory_write_data <= bus;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      a               <= 4'h0;
      b               <= 4'h0;
      x               <= '0;
      np              <= 4'h0;
      pc              <= PC_RESET;
      zero            <= 1'b0;
      carry           <= 1'b0;
      memory_write_en <= 1'b0;
    end else begin
      memory_write_en <= is_fetch && (uop.bus_output_selector == REG_MX);

      if (is_write) begin
        case (uop.bus_output_selector)
          REG_A:     a <= bus;
          REG_B:     b <= bus;
          REG_XL:    x[3:0] <= bus;
          REG_XH:    x[7:4] <= bus;
          REG_XP:    x[11:8] <= bus;
          REG_NPP:   np <= bus;
          // Jump stays in the current bank
          REG_SETPC: pc <= {pc[PC_W-1], np, uop.immed};
          default: begin
          end
        endcase

        if (uop.bus_input_selector == REG_ALU_WITH_FLAGS) begin
          zero  <= alu_zero;
          carry <= alu_carry;
        end

        // Post-increment, after the address was used
        if (uop.increment_selector == REG_XHL) begin
          x[7:0] <= x[7:0] + 8'd1;
        end

        // Step bits only, wraps inside the page
        if (uop.increment_pc) begin
          pc[7:0] <= pc[7:0] + 8'd1;
        end
      end
    end
  end

  // The RAM write lands at the end of WRITE, never in another phase
  assert property (@(posedge clk) disable iff (reset)
    memory_write_en |-> uop.current_cycle == CYCLE_REG_WRITE);

endmodule

`default_nettype wire

/* sources.f */
source/core_pkg.sv
source/micro_op_if.sv
source/alu4.sv
source/data_ram.sv
source/instr_decode.sv
source/reg_file.sv
source/core_top.sv
tests/core_tb.sv

/* tests/core_tb.sv */
`default_nettype none

module core_tb import core_pkg::*; ();

  localparam int          CLK_HALF      = 4;
  localparam int          RESET_CYCLES  = 16;
  localparam int          WAIT_LIMIT    = 20;
  localparam int          RANDOM_ROUNDS = 24;
  localparam logic [31:0] SEED          = 32'h2b65_1892;

  // Arrives while ready is low, so the core must drop it
  localparam logic [OPCODE_W-1:0] BUSY_WORD = {OPC_LDI, LDI_A, 4'hF};
  // Opcode 1 has no meaning and only advances pc
  localparam logic [OPCODE_W-1:0] NOP_WORD  = {4'h1, 8'h00};

  // One instruction and the state expected after it
  typedef struct packed {
    logic [OPCODE_W-1:0]   word;
    logic [3:0]            a;
    logic [3:0]            b;
    logic [MEM_ADDR_W-1:0] x;
    logic [PC_W-1:0]       pc;
    logic                  zero;
    logic                  carry;
  } step_t;

  logic                  clk;
  logic                  reset;
  logic [OPCODE_W-1:0]   instr;
  logic                  instr_valid;
  logic                  ready;
  logic [3:0]            a;
  logic [3:0]            b;
  logic [MEM_ADDR_W-1:0] x;
  logic [PC_W-1:0]       pc;
  logic                  zero;
  logic                  carry;

  step_t       steps[$];
  step_t       model;
  int          mismatch_count;
  int          timeout_count;
  int          idx;
  int          op;
  logic [31:0] rnd;
  logic [3:0]  res;
  logic        cout;

  core_top DUT (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .ready       (ready),
    .a           (a),
    .b           (b),
    .x           (x),
    .pc          (pc),
    .zero        (zero),
    .carry       (carry)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  function automatic logic [OPCODE_W-1:0] ldi(input logic [3:0] target,
                                              input logic [3:0] nibble);
    return {OPC_LDI, target, nibble};
  endfunction

  // A op B into A
  function automatic logic [OPCODE_W-1:0] alu_instr(input logic [3:0] fn);
    return {OPC_ALU, fn, RC_A, RC_B};
  endfunction

  function automatic logic [OPCODE_W-1:0] mem_instr(input logic load, input logic inc,
                                                    input logic [1:0] rc);
    return {OPC_MEM, load, inc, 4'h0, rc};
  endfunction

  function automatic logic [OPCODE_W-1:0] jp(input logic [7:0] step);
    return {OPC_JP, step};
  endfunction

  function automatic logic [3:0] fn_code(input int sel);
    case (sel)
      0:       return ALU_FN_ADD;
      1:       return ALU_FN_ADC;
      2:       return ALU_FN_SUB;
      3:       return ALU_FN_AND;
      4:       return ALU_FN_OR;
      default: return ALU_FN_XOR;
    endcase
  endfunction

  // Reference ALU, carry is carry out on add and borrow on subtract
  task automatic ref_alu(input int sel, input logic [3:0] op_a, input logic [3:0] op_b,
                         input logic cin, output logic [3:0] r, output logic c);
    int full;
    full = 0;
    c    = 1'b0;
    case (sel)
      0: begin
        full = int'(op_a) + int'(op_b);
        c    = (full > 15);
      end
      1: begin
        full = int'(op_a) + int'(op_b) + int'(cin);
        c    = (full > 15);
      end
      2: begin
        full = int'(op_a) - int'(op_b);
        c    = (op_b > op_a);
      end
      3:       full = int'(op_a & op_b);
      4:       full = int'(op_a | op_b);
      default: full = int'(op_a ^ op_b);
    endcase
    r = full[3:0];
  endtask

  task automatic advance_pc();
    // Step bits only, the page stays
    model.pc[7:0] = model.pc[7:0] + 8'd1;
  endtask

  task automatic check_value(input string field, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is 0x%0h, expected 0x%0h",
               $time, field, actual, expected);
      mismatch_count++;
    end
  endtask

  task automatic check_state(input string tag, input step_t e);
    check_value({tag, ": ready"}, 32'(ready), 32'd1);
    check_value({tag, ": a"}, 32'(a), 32'(e.a));
    check_value({tag, ": b"}, 32'(b), 32'(e.b));
    check_value({tag, ": x"}, 32'(x), 32'(e.x));
    check_value({tag, ": pc"}, 32'(pc), 32'(e.pc));
    check_value({tag, ": zero"}, 32'(zero), 32'(e.zero));
    check_value({tag, ": carry"}, 32'(carry), 32'(e.carry));
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    timeout_count++;
  endtask

  task add_step(input logic [OPCODE_W-1:0] word, input logic [3:0] exp_a,
                input logic [3:0] exp_b, input logic [MEM_ADDR_W-1:0] exp_x,
                input logic [PC_W-1:0] exp_pc, input logic exp_zero, input logic exp_carry);
    steps.push_back({word, exp_a, exp_b, exp_x, exp_pc, exp_zero, exp_carry});
  endtask

  // Strobe one instruction, then hold a second strobe for the whole busy time
  task issue(input logic [OPCODE_W-1:0] word);
    int cycles;
    cycles = 0;
    while (!ready && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!ready) begin
      report_timeout("ready stayed low, no instruction could be issued");
    end else begin
      instr       = word;
      instr_valid = 1'b1;
      @(posedge clk);
      #1;
      check_value("ready after accept", 32'(ready), 32'd0);
      instr  = BUSY_WORD;
      cycles = 0;
      while (!ready && cycles < WAIT_LIMIT) begin
        @(posedge clk);
        #1;
        cycles++;
      end
      instr_valid = 1'b0;
      instr       = '0;
      if (!ready) begin
        report_timeout("ready did not return after an instruction");
      end else begin
        // Results land 3 edges after the accept edge
        check_value("latency", 32'(cycles), 32'd3);
      end
    end
  endtask

  task run_step(input string tag, input step_t e);
    issue(e.word);
    if (timeout_count == 0) begin
      check_state(tag, e);
    end
  endtask

  task build_table();
    // Immediate loads, one nibble each
    add_step(ldi(LDI_A, 4'h5),  4'h5, 4'h0, 12'h000, 13'h0101, 1'b0, 1'b0);
    add_step(ldi(LDI_B, 4'h3),  4'h5, 4'h3, 12'h000, 13'h0102, 1'b0, 1'b0);
    add_step(ldi(LDI_XL, 4'hC), 4'h5, 4'h3, 12'h00C, 13'h0103, 1'b0, 1'b0);
    add_step(ldi(LDI_XH, 4'hA), 4'h5, 4'h3, 12'h0AC, 13'h0104, 1'b0, 1'b0);
    add_step(ldi(LDI_XP, 4'h7), 4'h5, 4'h3, 12'h7AC, 13'h0105, 1'b0, 1'b0);
    // ALU into A with flags
    add_step(alu_instr(ALU_FN_ADD), 4'h8, 4'h3, 12'h7AC, 13'h0106, 1'b0, 1'b0);
    add_step(ldi(LDI_B, 4'hA),      4'h8, 4'hA, 12'h7AC, 13'h0107, 1'b0, 1'b0);
    add_step(alu_instr(ALU_FN_ADD), 4'h2, 4'hA, 12'h7AC, 13'h0108, 1'b0, 1'b1);
    add_step(alu_instr(ALU_FN_ADC), 4'hD, 4'hA, 12'h7AC, 13'h0109, 1'b0, 1'b0);
    add_step(alu_instr(ALU_FN_SUB), 4'h3, 4'hA, 12'h7AC, 13'h010A, 1'b0, 1'b0);
    add_step(alu_instr(ALU_FN_SUB), 4'h9, 4'hA, 12'h7AC, 13'h010B, 1'b0, 1'b1);
    add_step(alu_instr(ALU_FN_ADC), 4'h4, 4'hA, 12'h7AC, 13'h010C, 1'b0, 1'b1);
    add_step(alu_instr(ALU_FN_AND), 4'h0, 4'hA, 12'h7AC, 13'h010D, 1'b1, 1'b0);
    add_step(ldi(LDI_A, 4'hC),      4'hC, 4'hA, 12'h7AC, 13'h010E, 1'b1, 1'b0);
    add_step(alu_instr(ALU_FN_OR),  4'hE, 4'hA, 12'h7AC, 13'h010F, 1'b0, 1'b0);
    add_step(alu_instr(ALU_FN_XOR), 4'h4, 4'hA, 12'h7AC, 13'h0110, 1'b0, 1'b0);
    add_step(ldi(LDI_B, 4'h4),      4'h4, 4'h4, 12'h7AC, 13'h0111, 1'b0, 1'b0);
    add_step(alu_instr(ALU_FN_XOR), 4'h0, 4'h4, 12'h7AC, 13'h0112, 1'b1, 1'b0);
    add_step(ldi(LDI_A, 4'h8),      4'h8, 4'h4, 12'h7AC, 13'h0113, 1'b1, 1'b0);
    add_step(ldi(LDI_B, 4'h8),      4'h8, 4'h8, 12'h7AC, 13'h0114, 1'b1, 1'b0);
    add_step(alu_instr(ALU_FN_ADD), 4'h0, 4'h8, 12'h7AC, 13'h0115, 1'b1, 1'b1);
    // Stores with post-increment, then loads back from the old address
    add_step(ldi(LDI_XL, 4'h3),               4'h0, 4'h8, 12'h7A3, 13'h0116, 1'b1, 1'b1);
    add_step(ldi(LDI_A, 4'h9),                4'h9, 4'h8, 12'h7A3, 13'h0117, 1'b1, 1'b1);
    add_step(mem_instr(1'b0, 1'b1, RC_A),     4'h9, 4'h8, 12'h7A4, 13'h0118, 1'b1, 1'b1);
    add_step(ldi(LDI_A, 4'h6),                4'h6, 4'h8, 12'h7A4, 13'h0119, 1'b1, 1'b1);
    add_step(mem_instr(1'b0, 1'b1, RC_A),     4'h6, 4'h8, 12'h7A5, 13'h011A, 1'b1, 1'b1);
    add_step(ldi(LDI_XL, 4'h3),               4'h6, 4'h8, 12'h7A3, 13'h011B, 1'b1, 1'b1);
    add_step(mem_instr(1'b1, 1'b1, RC_B),     4'h6, 4'h9, 12'h7A4, 13'h011C, 1'b1, 1'b1);
    add_step(mem_instr(1'b1, 1'b0, RC_B),     4'h6, 4'h6, 12'h7A4, 13'h011D, 1'b1, 1'b1);
    add_step(ldi(LDI_XL, 4'hF),               4'h6, 4'h6, 12'h7AF, 13'h011E, 1'b1, 1'b1);
    add_step(mem_instr(1'b0, 1'b1, RC_A),     4'h6, 4'h6, 12'h7B0, 13'h011F, 1'b1, 1'b1);
    // Jumps inside a page built from NP
    add_step(ldi(LDI_NP, 4'h3), 4'h6, 4'h6, 12'h7B0, 13'h0120, 1'b1, 1'b1);
    add_step(jp(8'h45),         4'h6, 4'h6, 12'h7B0, 13'h0345, 1'b1, 1'b1);
    add_step(ldi(LDI_A, 4'h7),  4'h7, 4'h6, 12'h7B0, 13'h0346, 1'b1, 1'b1);
    add_step(NOP_WORD,          4'h7, 4'h6, 12'h7B0, 13'h0347, 1'b1, 1'b1);
    add_step(jp(8'hFF),         4'h7, 4'h6, 12'h7B0, 13'h03FF, 1'b1, 1'b1);
    add_step(NOP_WORD,          4'h7, 4'h6, 12'h7B0, 13'h0300, 1'b1, 1'b1);
  endtask

  initial begin
    rnd            = $urandom(SEED);
    reset          = 1'b1;
    instr          = '0;
    instr_valid    = 1'b0;
    mismatch_count = 0;
    timeout_count  = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    check_state("reset", {NOP_WORD, 4'h0, 4'h0, 12'h000, PC_RESET, 1'b0, 1'b0});

    build_table();
    for (idx = 0; idx < steps.size() && timeout_count == 0; idx++) begin
      run_step($sformatf("step %0d", idx), steps[idx]);
    end

    // Random operands against the reference model
    model = steps[steps.size() - 1];
    for (idx = 0; idx < RANDOM_ROUNDS && timeout_count == 0; idx++) begin
      rnd        = $urandom();
      op         = int'(rnd[10:8]) % 6;
      model.word = ldi(LDI_A, rnd[3:0]);
      model.a    = rnd[3:0];
      advance_pc();
      run_step($sformatf("random %0d load a", idx), model);
      model.word = ldi(LDI_B, rnd[7:4]);
      model.b    = rnd[7:4];
      advance_pc();
      run_step($sformatf("random %0d load b", idx), model);
      model.word = alu_instr(fn_code(op));
      ref_alu(op, model.a, model.b, model.carry, res, cout);
      model.a     = res;
      model.zero  = (res == 4'h0);
      model.carry = cout;
      advance_pc();
      run_step($sformatf("random %0d alu op %0d", idx, op), model);
    end

    $display("checks done: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
